/* tb.f */
+incdir+logic
logic/rssi_pkg.sv
logic/setting_reg.sv
logic/register_io.sv
logic/rssi_meter.sv
logic/squelch_gate.sv
logic/rx_monitor_top.sv
verification/rx_monitor_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rx_monitor_tb
FILELIST  = tb.f
OBJ       = obj_dir
PASS      = No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)

sim: build
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ)

/* verification/rx_monitor_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rssi_defines.svh"

module rx_monitor_tb;

    import rssi_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    sample_t     smp [4];
    logic [3:0]  stb;
    logic [1:0]  enable;
    reg_addr_t   addr;
    reg_data_t   datain;
    reg_data_t   dataout;
    logic [15:0] debugbus;
    logic        squelch_open;

    rssi_t       m_rssi [4];
    reg_data_t   m_set [`NUM_SETTINGS];
    reg_data_t   m_out;
    reg_data_t   m_cnt;
    logic        m_open;
    logic        prev_open;
    reg_data_t   written [`NUM_SETTINGS];
    logic [15:0] lfsr_state;
    int          cyc = 0;
    int          last_loud = 0;
    int          dut_close = 0;
    int          errors = 0;
    int          checks = 0;

    rx_monitor_top rx_monitor_top_i
    (
        .clk(clk), .rst(rst),
        .sample_0(smp[0]), .sample_1(smp[1]), .sample_2(smp[2]), .sample_3(smp[3]),
        .sample_stb_0(stb[0]), .sample_stb_1(stb[1]),
        .sample_stb_2(stb[2]), .sample_stb_3(stb[3]),
        .enable(enable), .addr(addr), .datain(datain), .dataout(dataout),
        .debugbus(debugbus), .squelch_open(squelch_open)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // magnitude clipped to 32767, then leaky average
    function automatic rssi_t rssi_next(input rssi_t old, input sample_t s);
        int v;
        v = int'(s);
        if (v < 0)
            v = -v;
        if (v > 32767)
            v = 32767;
        return old - (old >> `RSSI_SHIFT) + rssi_t'(v);
    endfunction

    function automatic reg_data_t read_rule(input reg_addr_t a);
        int ia;
        ia = int'(a);
        if (ia >= `ADDR_RSSI_BASE && ia < `ADDR_RSSI_BASE + 4)
            return m_rssi[ia - `ADDR_RSSI_BASE];
        return m_set[ia % `NUM_SETTINGS];
    endfunction

    // returns {open, quiet count} after one edge
    function automatic logic [32:0] squelch_step(input logic open, input reg_data_t cnt,
                                                 input logic loud, input reg_data_t hang);
        if (loud)
            return {1'b1, 32'd0};
        if (!open)
            return {1'b0, cnt};
        return {cnt != hang, cnt + 32'd1};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    // model runs on the values sampled at each edge
    always @(posedge clk)
    begin
        logic        loud;
        logic [32:0] sq;
        reg_data_t   next_out;
        if (rst)
        begin
            m_rssi = '{default: '0};
            m_set = '{default: '0};
            m_out = '0;
            m_cnt = '0;
            m_open = 1'b0;
            prev_open = 1'b0;
        end
        else
        begin
            check_equal("dataout", dataout, m_out);
            check_equal("squelch_open", 32'(squelch_open), 32'(m_open));
            if (prev_open && !squelch_open)
                dut_close = cyc - 1;
            prev_open = squelch_open;
            loud = 1'b0;
            for (int ch = 0; ch < 4; ch++)
                if (m_rssi[ch] > m_set[`ADDR_THRESHHOLD])
                    loud = 1'b1;
            if (loud)
                last_loud = cyc;
            sq = squelch_step(m_open, m_cnt, loud, m_set[`ADDR_RSSI_WAIT]);
            next_out = !enable[1] ? 32'd0 : (enable[0] ? read_rule(addr) : m_out);
            if (enable == 2'b10 && int'(addr) < `NUM_SETTINGS)
                m_set[addr[2:0]] = datain;
            for (int ch = 0; ch < 4; ch++)
                if (stb[ch])
                    m_rssi[ch] = rssi_next(m_rssi[ch], smp[ch]);
            m_open = sq[32];
            m_cnt = sq[31:0];
            m_out = next_out;
        end
        cyc = cyc + 1;
    end

    // debug bus sampled inside the high phase of clk
    always @(posedge clk)
    begin
        #2;
        if (!rst)
            check_equal("debugbus", 32'(debugbus),
                        32'({1'b1, enable, addr[2:0], datain[4:0], m_out[4:0]}));
    end

    task automatic bus_write(input int a, input reg_data_t d);
        @(posedge clk);
        enable <= 2'b10;
        addr <= reg_addr_t'(a);
        datain <= d;
        @(posedge clk);
        enable <= 2'b00;
    endtask

    task automatic bus_read(input int a);
        @(posedge clk);
        enable <= 2'b11;
        addr <= reg_addr_t'(a);
    endtask

    task automatic read_expect(input int a, input reg_data_t exp);
        bus_read(a);
        @(posedge clk);
        enable <= 2'b00;
        @(posedge clk);
        check_equal("dataout", dataout, exp);
    endtask

    task automatic drive_samples(input int n, input logic rnd, input sample_t v,
                                 input logic [3:0] mask);
        repeat (n)
        begin
            @(posedge clk);
            for (int ch = 0; ch < 4; ch++)
            begin
                smp[ch] <= rnd ? sample_t'(rand_bits(16)) : v;
                stb[ch] <= rnd ? 1'(rand_bits(1)) : mask[ch];
            end
        end
    endtask

    task automatic wait_gate(input logic want, input int limit);
        int n;
        n = 0;
        while (squelch_open !== want && n < limit)
        begin
            @(posedge clk);
            n++;
        end
        if (squelch_open !== want)
        begin
            errors++;
            $display("timeout: squelch_open did not reach %0d in %0d cycles", want, limit);
        end
    endtask

    task automatic hang_run(input int hang);
        drive_samples(2, 1'b0, 16'sh7fff, 4'b0010); // loud burst on channel 1
        drive_samples(1, 1'b0, 16'sh0000, 4'b1111); // zeros keep decaying
        wait_gate(1'b1, 20);
        wait_gate(1'b0, 300);
        @(posedge clk);
        check_equal("hang_cycles", 32'(dut_close - last_loud), 32'(hang + 1));
    endtask

    initial
    begin
        lfsr_state = 16'd6684;
        rst = 1'b1;
        enable = 2'b00;
        addr = '0;
        datain = '0;
        stb = '0;
        smp = '{default: '0};
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_equal("dataout", dataout, 32'd0);
        check_equal("squelch_open", 32'(squelch_open), 32'd0);
        for (int ch = 0; ch < 4; ch++)
            read_expect(`ADDR_RSSI_BASE + ch, 32'd0);

        for (int a = 0; a < `NUM_SETTINGS; a++)
        begin
            written[a] = 32'h1234_5678 ^ (32'(a) * 32'h0101_0101);
            bus_write(a, written[a]);
        end
        for (int a = 0; a < `NUM_SETTINGS; a++)
            read_expect(a, written[a]);
        read_expect(8, written[0]);
        for (int a = 13; a < 16; a++)
            read_expect(a, written[a % `NUM_SETTINGS]);

        drive_samples(60, 1'b1, 16'sh0000, 4'b0000);
        drive_samples(1, 1'b0, 16'sh8000, 4'b1111); // most negative saturates
        drive_samples(1, 1'b0, 16'sh0000, 4'b0000);
        @(posedge clk);
        for (int ch = 0; ch < 4; ch++)
            read_expect(`ADDR_RSSI_BASE + ch, m_rssi[ch]);
        fork
            drive_samples(40, 1'b1, 16'sh0000, 4'b0000);
            for (int r = 0; r < 16; r++)
                bus_read(`ADDR_RSSI_BASE + (r % 4));
        join
        drive_samples(1, 1'b0, 16'sh0000, 4'b0000);

        repeat (3) bus_read(3);
        @(posedge clk);
        enable <= 2'b00;
        repeat (2) @(posedge clk);
        check_equal("dataout", dataout, 32'd0);
        bus_read(3);
        repeat (2) @(posedge clk);
        check_equal("dataout", dataout, written[3]);
        bus_write(5, 32'hdead_beef);
        @(posedge clk);
        check_equal("dataout", dataout, written[3]);

        bus_write(`ADDR_THRESHHOLD, 32'h0000_1000);
        bus_write(`ADDR_RSSI_WAIT, 32'd5);
        drive_samples(200, 1'b0, 16'sh0000, 4'b1111);
        wait_gate(1'b0, 50);
        hang_run(5);
        bus_write(`ADDR_RSSI_WAIT, 32'd0);
        hang_run(0);

        repeat (3) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/rx_monitor_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_monitor_top
    (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire rssi_pkg::sample_t   sample_0,
    input  wire rssi_pkg::sample_t   sample_1,
    input  wire rssi_pkg::sample_t   sample_2,
    input  wire rssi_pkg::sample_t   sample_3,
    input  wire logic                sample_stb_0,
    input  wire logic                sample_stb_1,
    input  wire logic                sample_stb_2,
    input  wire logic                sample_stb_3,
    input  wire logic [1:0]          enable,
    input  wire rssi_pkg::reg_addr_t addr,
    input  wire rssi_pkg::reg_data_t datain,
    output rssi_pkg::reg_data_t      dataout,
    output wire logic [15:0]         debugbus,
    output logic                     squelch_open
    );

    import rssi_pkg::*;

    rssi_t     rssi_0;
    rssi_t     rssi_1;
    rssi_t     rssi_2;
    rssi_t     rssi_3;
    reg_data_t threshhold;
    reg_data_t rssi_wait;

    rssi_meter meter_0 (.clk(clk), .rst(rst), .sample(sample_0), .sample_stb(sample_stb_0),
                        .rssi(rssi_0));
    rssi_meter meter_1 (.clk(clk), .rst(rst), .sample(sample_1), .sample_stb(sample_stb_1),
                        .rssi(rssi_1));
    rssi_meter meter_2 (.clk(clk), .rst(rst), .sample(sample_2), .sample_stb(sample_stb_2),
                        .rssi(rssi_2));
    rssi_meter meter_3 (.clk(clk), .rst(rst), .sample(sample_3), .sample_stb(sample_stb_3),
                        .rssi(rssi_3));

    register_io register_io_i
    (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .addr(addr),
        .datain(datain),
        .dataout(dataout),
        .debugbus(debugbus),
        .rssi_0(rssi_0),
        .rssi_1(rssi_1),
        .rssi_2(rssi_2),
        .rssi_3(rssi_3),
        .threshhold(threshhold),
        .rssi_wait(rssi_wait)
    );

    squelch_gate squelch_gate_i
    (
        .clk(clk),
        .rst(rst),
        .rssi_0(rssi_0),
        .rssi_1(rssi_1),
        .rssi_2(rssi_2),
        .rssi_3(rssi_3),
        .threshhold(threshhold),
        .rssi_wait(rssi_wait),
        .squelch_open(squelch_open)
    );

endmodule

`default_nettype wire

/* logic/squelch_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module squelch_gate
    (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire rssi_pkg::rssi_t     rssi_0,
    input  wire rssi_pkg::rssi_t     rssi_1,
    input  wire rssi_pkg::rssi_t     rssi_2,
    input  wire rssi_pkg::rssi_t     rssi_3,
    input  wire rssi_pkg::reg_data_t threshhold,
    input  wire rssi_pkg::reg_data_t rssi_wait,
    output logic                     squelch_open
    );

    import rssi_pkg::*;

    logic      loud;
    reg_data_t quiet_cnt;

    assign loud = (rssi_0 > threshhold) || (rssi_1 > threshhold) ||
                  (rssi_2 > threshhold) || (rssi_3 > threshhold);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            squelch_open <= 1'b0;
            quiet_cnt    <= '0;
        end
        else if (loud)
        begin
            squelch_open <= 1'b1;
            quiet_cnt    <= '0; // restart hang time
        end
        else if (squelch_open)
        begin
            quiet_cnt <= quiet_cnt + 32'd1;
            if (quiet_cnt == rssi_wait)
            begin
                squelch_open <= 1'b0; // hang time used up
            end
        end
    end

    // opening needs a loud channel at the previous edge
    assert property (@(posedge clk) disable iff (rst) !loud |=> !$rose(squelch_open));

endmodule

`default_nettype wire

/* logic/rssi_meter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rssi_defines.svh"

module rssi_meter
    (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire rssi_pkg::sample_t sample,
    input  wire logic              sample_stb,
    output rssi_pkg::rssi_t        rssi
    );

    import rssi_pkg::*;

    logic [15:0] abs_val;
    rssi_t       mag;

    always_comb
    begin
        if (sample == sample_t'(16'h8000))
        begin
            abs_val = 16'h7fff; // saturate most negative
        end
        else if (sample < 0)
        begin
            abs_val = 16'(-sample);
        end
        else
        begin
            abs_val = 16'(sample);
        end
        mag = rssi_t'(abs_val);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rssi <= '0;
        end
        else if (sample_stb)
        begin
            rssi <= rssi - (rssi >> `RSSI_SHIFT) + mag;
        end
    end

    // average only moves on a strobe
    assert property (@(posedge clk) disable iff (rst) !sample_stb |=> $stable(rssi));

endmodule

`default_nettype wire

/* logic/register_io.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rssi_defines.svh"

module register_io
    (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [1:0]          enable,
    input  wire rssi_pkg::reg_addr_t addr,
    input  wire rssi_pkg::reg_data_t datain,
    output rssi_pkg::reg_data_t      dataout,
    output wire logic [15:0]         debugbus,
    input  wire rssi_pkg::rssi_t     rssi_0,
    input  wire rssi_pkg::rssi_t     rssi_1,
    input  wire rssi_pkg::rssi_t     rssi_2,
    input  wire rssi_pkg::rssi_t     rssi_3,
    output rssi_pkg::reg_data_t      threshhold,
    output rssi_pkg::reg_data_t      rssi_wait
    );

    import rssi_pkg::*;

    logic      strobe;
    reg_data_t settings [`NUM_SETTINGS];
    reg_data_t read_val;

    // bit 1 selects, bit 0 low means write
    assign strobe = enable[1] && !enable[0];

    genvar i;
    generate
        for (i = 0; i < `NUM_SETTINGS; i++)
        begin : g_setting
            setting_reg #(.my_addr(i)) setting_reg_i
            (
                .clk(clk),
                .rst(rst),
                .strobe(strobe),
                .addr(addr),
                .in(datain),
                .out(settings[i])
            );
        end
    endgenerate

    always_comb
    begin
        case (addr)
            reg_addr_t'(`ADDR_RSSI_BASE):     read_val = rssi_0;
            reg_addr_t'(`ADDR_RSSI_BASE + 1): read_val = rssi_1;
            reg_addr_t'(`ADDR_RSSI_BASE + 2): read_val = rssi_2;
            reg_addr_t'(`ADDR_RSSI_BASE + 3): read_val = rssi_3;
            default:                          read_val = settings[addr[2:0]]; // aliases every 8
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || !enable[1])
        begin
            dataout <= '0;
        end
        else if (enable[0])
        begin
            dataout <= read_val;
        end
        // writes leave dataout alone
    end

    assign threshhold = settings[`ADDR_THRESHHOLD];
    assign rssi_wait  = settings[`ADDR_RSSI_WAIT];

    assign debugbus = {clk, enable, addr[2:0], datain[4:0], dataout[4:0]};

    // idle bus always reads back as zero
    assert property (@(posedge clk) disable iff (rst) !enable[1] |=> dataout == '0);

endmodule

`default_nettype wire

/* logic/setting_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module setting_reg
    #(
    parameter int my_addr = 0
    )
    (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               strobe,
    input  wire rssi_pkg::reg_addr_t addr,
    input  wire rssi_pkg::reg_data_t in,
    output rssi_pkg::reg_data_t     out
    );

    import rssi_pkg::*;

    logic hit;

    assign hit = strobe && (addr == reg_addr_t'(my_addr)); // only address check on writes

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out <= '0;
        end
        else if (hit)
        begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

/* logic/rssi_pkg.sv */
`default_nettype none

package rssi_pkg;

    // signed receive sample from the rx chain
    typedef logic signed [15:0] sample_t;

    // leaky-average signal strength, unsigned
    typedef logic [31:0] rssi_t;

    // host register bus
    typedef logic [6:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

endpackage

`default_nettype wire

/* logic/rssi_defines.svh */
`ifndef RSSI_DEFINES_SVH
`define RSSI_DEFINES_SVH

// number of host setting registers
`define NUM_SETTINGS 8

// setting addresses used by the squelch
`define ADDR_THRESHHOLD 1
`define ADDR_RSSI_WAIT 2

// rssi values sit at base .. base+3
`define ADDR_RSSI_BASE 9

// leaky average decay, old - (old >> shift)
`define RSSI_SHIFT 4

`endif
